//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module exec_tb -f exec.f
	out=$$(./obj_dir/Vexec_tb); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- dv/exec_tb.sv
// self-checking testbench for exec_top, needs Verilator with --timing and --assert
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

    localparam int  PERIOD    = 40;
    localparam int  N_ALU     = 60;
    localparam int  N_CMOV    = 16;
    localparam int  N_XCHG    = 8;
    localparam int  N_BR      = 24;
    localparam int  N_CRED    = 40;
    // branches may bring two wrong-path ops and one good op
    localparam int  TOTAL_OPS = N_ALU + 2 * N_CMOV + N_XCHG + 4 * N_BR + N_CRED + 8;
    localparam longint TIMEOUT_NS = longint'(TOTAL_OPS) * 20 * PERIOD;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic in_valid = 1'b0, in_epoch = 1'b0, in_pred_taken = 1'b0, in_ready;
    exec_op_t in_op = OP_NOP;
    logic [DATA_W-1:0] in_op1 = '0, in_op2 = '0, in_next_eip = '0, in_pred_target = '0;
    logic [DEST_W-1:0] in_dest1 = '0, in_dest2 = '0;
    logic res_valid, res_two, br_valid, br_taken, br_mispredict, halted;
    logic res_credit = 1'b0, br_credit = 1'b0;
    logic [DATA_W-1:0] res_data1, res_data2, br_target;
    logic [DEST_W-1:0] res_dest1, res_dest2;
    logic [FLAG_W-1:0] flags;

    // reference model state and scoreboards
    logic [FLAG_W-1:0] m_flags;
    logic              m_epoch;
    logic [31:0]       lfsr = 32'd41;
    logic [70:0]       exp_res[$];
    logic [33:0]       exp_br[$];
    string             test_name = "reset";
    int errors = 0, checks = 0, tests = 0;
    // credit mode 0 returns at once, 1 withholds, 2 returns randomly
    int credit_mode = 0;
    int res_owed, br_owed, res_beats, br_beats, res_ret, br_ret;

    exec_top uut (.*);

    always #(PERIOD / 2) clk = ~clk;

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: DUT stopped producing entries in test %s", test_name);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rnd(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [FLAG_W-1:0] result_flags(input logic [FLAG_W-1:0] f,
                                                      input logic [31:0] r);
        logic [FLAG_W-1:0] o;
        o = f;
        o[FLAG_PF] = ~^r[7:0];
        o[FLAG_ZF] = (r == 32'd0);
        o[FLAG_SF] = r[31];
        return o;
    endfunction

    // apply one accepted op to the model and queue what it should produce
    task automatic model_op(input exec_op_t op, input logic [31:0] a, input logic [31:0] b,
                            input logic [2:0] d1, input logic [2:0] d2, input logic ep,
                            input logic pt, input logic [31:0] ptgt, input logic [31:0] nxt);
        logic [32:0] s;
        logic [31:0] r;
        logic [4:0]  n;
        logic        tk;
        logic        mis;
        if (ep != m_epoch) return;
        n = b[4:0];
        r = b;
        case (op)
            OP_ADD: begin
                s = {1'b0, a} + {1'b0, b};
                r = s[31:0];
                m_flags = result_flags(m_flags, r);
                m_flags[FLAG_CF] = s[32];
                m_flags[FLAG_OF] = (a[31] == b[31]) && (r[31] != a[31]);
            end
            OP_AND, OP_OR: begin
                r = (op == OP_AND) ? (a & b) : (a | b);
                m_flags = result_flags(m_flags, r);
                m_flags[FLAG_CF] = 1'b0;
                m_flags[FLAG_OF] = 1'b0;
            end
            OP_NOT: r = ~a;
            OP_SAL, OP_SAR: begin
                r = (op == OP_SAL) ? (a << n) : 32'($signed(a) >>> n);
                if (n != 5'd0) begin
                    m_flags = result_flags(m_flags, r);
                    m_flags[FLAG_CF] = (op == OP_SAL) ? a[6'd32 - n] : a[n - 5'd1];
                end
            end
            default: r = b;
        endcase
        if (op inside {OP_ADD, OP_AND, OP_OR, OP_NOT, OP_SAL, OP_SAR, OP_MOV})
            exp_res.push_back({r, d1, 32'd0, 3'd0, 1'b0});
        if (op == OP_CMOVC && m_flags[FLAG_CF])
            exp_res.push_back({b, d1, 32'd0, 3'd0, 1'b0});
        if (op == OP_XCHG)
            exp_res.push_back({b, d1, a, d2, 1'b1});
        if (op inside {OP_JMP, OP_JC, OP_JZ}) begin
            tk = (op == OP_JMP) || (op == OP_JC && m_flags[FLAG_CF]) ||
                 (op == OP_JZ && m_flags[FLAG_ZF]);
            mis = (tk != pt) || (tk && (b != ptgt));
            exp_br.push_back({tk, mis, tk ? b : nxt});
            if (mis) m_epoch = ~m_epoch;
        end
    endtask

    // drive one op on the falling edge and hold it until in_ready
    task automatic send_op(input exec_op_t op, input logic [31:0] a, input logic [31:0] b,
                           input logic ep, input logic pt, input logic [31:0] ptgt);
        logic [31:0] d;
        logic [31:0] nxt;
        rnd(6, d);
        rnd(32, nxt);
        @(negedge clk);
        in_valid = 1'b1;
        in_op = op;
        in_op1 = a;
        in_op2 = b;
        in_dest1 = d[2:0];
        in_dest2 = d[5:3];
        in_epoch = ep;
        in_pred_taken = pt;
        in_pred_target = ptgt;
        in_next_eip = nxt;
        while (!in_ready) @(negedge clk);
        model_op(op, a, b, d[2:0], d[5:3], ep, pt, ptgt, nxt);
    endtask

    task automatic drain();
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_res.size() != 0 || exp_br.size() != 0) @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    task automatic check_flags();
        checks++;
        assert (flags == m_flags) else begin
            errors++;
            $display("mismatch test=%s flags exp=%h act=%h", test_name, m_flags, flags);
        end
    endtask

    task automatic end_test();
        drain();
        check_flags();
        tests++;
        $display("test %s done, %0d errors so far", test_name, errors);
    endtask

    task automatic do_reset();
        rst = 1'b1;
        in_valid = 1'b0;
        exp_res.delete();
        exp_br.delete();
        m_flags = '0;
        m_epoch = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    // beat checks and credit returns, all on the falling edge
    always @(negedge clk) begin
        logic [70:0] act;
        logic [70:0] exp;
        logic [31:0] r;
        if (rst) begin
            res_owed = 0;
            br_owed = 0;
            res_beats = 0;
            br_beats = 0;
            res_ret = 0;
            br_ret = 0;
            res_credit = 1'b0;
            br_credit = 1'b0;
        end else begin
            if (res_valid) begin
                res_beats++;
                res_owed++;
                checks++;
                act = {res_data1, res_dest1, res_data2, res_dest2, res_two};
                if (exp_res.size() == 0) begin
                    errors++;
                    $display("test %s: result entry arrived with none expected", test_name);
                end else begin
                    exp = exp_res.pop_front();
                    // second write fields only matter when two is expected
                    if (!exp[0]) act[35:1] = '0;
                    assert (act == exp) else begin
                        errors++;
                        $display("mismatch test=%s result exp=%h act=%h", test_name, exp, act);
                    end
                end
            end
            if (br_valid) begin
                br_beats++;
                br_owed++;
                checks++;
                if (exp_br.size() == 0) begin
                    errors++;
                    $display("test %s: branch entry arrived with none expected", test_name);
                end else begin
                    exp = {37'd0, exp_br.pop_front()};
                    assert (exp[33:0] == {br_taken, br_mispredict, br_target}) else begin
                        errors++;
                        $display("mismatch test=%s branch exp=%h act=%h", test_name,
                                 exp[33:0], {br_taken, br_mispredict, br_target});
                    end
                end
            end
            // never more beats than credits granted
            assert (res_beats <= EXEC_CREDITS + res_ret && br_beats <= EXEC_CREDITS + br_ret)
            else begin
                errors++;
                $display("test %s: more valid beats than credits granted", test_name);
            end
            rnd(2, r);
            res_credit = (res_owed > 0) && (credit_mode == 0 || (credit_mode == 2 && r[0]));
            br_credit  = (br_owed > 0) && (credit_mode == 0 || (credit_mode == 2 && r[1]));
            if (res_credit) begin
                res_owed--;
                res_ret++;
            end
            if (br_credit) begin
                br_owed--;
                br_ret++;
            end
        end
    end

    initial begin
        logic [31:0] a, b, c, p;
        exec_op_t op;
        logic old_ep;
        do_reset();

        test_name = "alu_flags";
        for (int i = 0; i < N_ALU; i++) begin
            rnd(32, a);
            rnd(32, b);
            rnd(3, c);
            op = exec_op_t'(4'd1 + 4'(c % 6));
            // every fourth op is a shift with a zero count
            if (i % 4 == 0) begin
                op = (i % 8 == 0) ? OP_SAL : OP_SAR;
                b[4:0] = 5'd0;
            end
            send_op(op, a, b, m_epoch, 1'b0, 32'd0);
            drain();
            check_flags();
        end
        end_test();

        test_name = "cmovc";
        for (int i = 0; i < N_CMOV; i++) begin
            rnd(32, a);
            rnd(32, b);
            rnd(1, c);
            // all ones plus an odd value carries, zero plus it does not
            send_op(OP_ADD, c[0] ? 32'hffff_ffff : 32'd0, a | 32'd1, m_epoch, 1'b0, 32'd0);
            send_op(OP_CMOVC, a, b, m_epoch, 1'b0, 32'd0);
        end
        end_test();

        test_name = "xchg";
        for (int i = 0; i < N_XCHG; i++) begin
            rnd(32, a);
            rnd(32, b);
            send_op(OP_XCHG, a, b, m_epoch, 1'b0, 32'd0);
        end
        end_test();

        test_name = "branch_squash";
        for (int i = 0; i < N_BR; i++) begin
            rnd(32, a);
            rnd(32, b);
            rnd(5, c);
            op = exec_op_t'(OP_JMP + 4'(c[1:0] % 3));
            p = c[2] ? b : a;
            old_ep = m_epoch;
            send_op(op, a, b, m_epoch, c[3], p);
            if (m_epoch != old_ep) begin
                send_op(OP_ADD, a, b, old_ep, 1'b0, 32'd0);
                send_op(OP_MOV, a, b, old_ep, 1'b0, 32'd0);
                // a zero sum sets ZF and CF for the branches that follow
                send_op(OP_ADD, a, c[4] ? (32'd0 - a) : b, m_epoch, 1'b0, 32'd0);
            end
        end
        end_test();

        test_name = "credits";
        credit_mode = 1;
        fork
            begin
                repeat (30) @(negedge clk);
                credit_mode = 2;
            end
        join_none
        for (int i = 0; i < N_CRED; i++) begin
            rnd(32, a);
            rnd(32, b);
            op = b[0] ? OP_MOV : OP_JMP;
            send_op(op, a, b, m_epoch, 1'b1, b);
        end
        end_test();
        credit_mode = 0;

        test_name = "halt";
        send_op(OP_ADD, 32'd5, 32'd7, m_epoch, 1'b0, 32'd0);
        send_op(OP_MOV, 32'd0, 32'd9, m_epoch, 1'b0, 32'd0);
        send_op(OP_HLT, 32'd0, 32'd0, m_epoch, 1'b0, 32'd0);
        @(negedge clk);
        in_op = OP_MOV;
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            checks++;
            assert (!in_ready) else begin
                errors++;
                $display("test %s: in_ready high after HLT", test_name);
            end
        end
        checks++;
        assert (halted) else begin
            errors++;
            $display("test %s: halted did not rise after HLT", test_name);
        end
        end_test();
        do_reset();
        @(negedge clk);
        checks++;
        assert (!halted && in_ready) else begin
            errors++;
            $display("test %s: stage still halted after reset", test_name);
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- exec.f
source/exec_pkg.sv
source/exec_alu.sv
source/exec_flags.sv
source/exec_branch.sv
source/exec_credit_counter.sv
source/exec_ctrl_fsm.sv
source/exec_out_queue.sv
source/exec_top.sv
dv/exec_tb.sv

//--- source/exec_alu.sv
// combinational ALU, shift counts use op2[4:0] only, OF is left unchanged by shifts
`timescale 1ns/1ps

module exec_alu import exec_pkg::*; (
    input  exec_op_t          op,
    input  logic [DATA_W-1:0] op1,
    input  logic [DATA_W-1:0] op2,
    input  logic [FLAG_W-1:0] flags_cur,
    output logic [DATA_W-1:0] data1,
    output logic [DATA_W-1:0] data2,
    output logic [FLAG_W-1:0] flags_new,
    output logic [FLAG_W-1:0] flags_we
);

    logic [DATA_W:0]   sum_w;
    logic [DATA_W:0]   sal_w;
    logic [DATA_W:0]   sar_w;
    logic [4:0]        shamt;

    // carry out in the top bit
    assign sum_w = {1'b0, op1} + {1'b0, op2};
    assign shamt = op2[4:0];
    // top bit ends up as the last bit shifted out
    assign sal_w = {1'b0, op1} << shamt;
    // bit 0 ends up as the last bit shifted out
    assign sar_w = $signed({op1, 1'b0}) >>> shamt;

    always_comb begin
        data1     = op2;
        data2     = '0;
        flags_new = flags_cur;
        flags_we  = '0;
        case (op)
            OP_ADD: begin
                data1              = sum_w[DATA_W-1:0];
                flags_we           = '1;
                flags_new[FLAG_CF] = sum_w[DATA_W];
                // signed overflow, same sign in and different sign out
                flags_new[FLAG_OF] = (op1[DATA_W-1] == op2[DATA_W-1]) &&
                                     (sum_w[DATA_W-1] != op1[DATA_W-1]);
            end
            OP_AND, OP_OR: begin
                data1              = (op == OP_AND) ? (op1 & op2) : (op1 | op2);
                flags_we           = '1;
                flags_new[FLAG_CF] = 1'b0;
                flags_new[FLAG_OF] = 1'b0;
            end
            OP_NOT: begin
                data1 = ~op1;
            end
            OP_SAL, OP_SAR: begin
                data1 = (op == OP_SAL) ? sal_w[DATA_W-1:0] : sar_w[DATA_W:1];
                // zero count leaves all flags alone
                if (shamt != 5'd0) begin
                    flags_we[FLAG_CF] = 1'b1;
                    flags_we[FLAG_PF] = 1'b1;
                    flags_we[FLAG_ZF] = 1'b1;
                    flags_we[FLAG_SF] = 1'b1;
                    flags_new[FLAG_CF] = (op == OP_SAL) ? sal_w[DATA_W] : sar_w[0];
                end
            end
            OP_XCHG: begin
                data1 = op2;
                data2 = op1;
            end
            // MOV, CMOVC and branches pass op2
            default: begin
                data1 = op2;
            end
        endcase
        // result flags, PF is even parity of low byte
        if (flags_we[FLAG_ZF]) begin
            flags_new[FLAG_PF] = ~^data1[7:0];
            flags_new[FLAG_ZF] = (data1 == '0);
            flags_new[FLAG_SF] = data1[DATA_W-1];
        end
    end

endmodule

//--- source/exec_branch.sv
// near branch resolution only, target comes in through op2, no far or indirect jumps
`timescale 1ns/1ps

module exec_branch import exec_pkg::*; (
    input  exec_op_t          op,
    input  logic [FLAG_W-1:0] flags,
    input  logic [DATA_W-1:0] target,
    input  logic [DATA_W-1:0] next_eip,
    input  logic [DATA_W-1:0] pred_target,
    input  logic              pred_taken,
    output logic              is_branch,
    output logic              taken,
    output logic              mispredict,
    output logic [DATA_W-1:0] resolved_target
);

    always_comb begin
        is_branch = 1'b0;
        taken     = 1'b0;
        case (op)
            OP_JMP: begin
                is_branch = 1'b1;
                taken     = 1'b1;
            end
            OP_JC: begin
                is_branch = 1'b1;
                taken     = flags[FLAG_CF];
            end
            OP_JZ: begin
                is_branch = 1'b1;
                taken     = flags[FLAG_ZF];
            end
            default: begin
                is_branch = 1'b0;
                taken     = 1'b0;
            end
        endcase
    end

    // where fetch should really go next
    assign resolved_target = taken ? target : next_eip;

    // wrong direction, or right direction with a wrong target
    assign mispredict = is_branch &&
                        ((taken != pred_taken) || (taken && (target != pred_target)));

endmodule

//--- source/exec_credit_counter.sv
// credit counter for one output channel, the receiver never returns more than EXEC_CREDITS
`timescale 1ns/1ps

module exec_credit_counter import exec_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic credit_return,
    input  logic spend,
    output logic has_credit
);

    logic [CREDIT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= CREDIT_W'(EXEC_CREDITS);
        end else begin
            // return and spend together cancel
            case ({credit_return, spend})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign has_credit = (count != '0);

endmodule

//--- source/exec_ctrl_fsm.sv
// stage control, in_op and in_epoch are the staged values from the input register
`timescale 1ns/1ps

module exec_ctrl_fsm import exec_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  logic     in_epoch,
    input  exec_op_t in_op,
    input  logic     space_ok,
    input  logic     cmov_ok,
    input  logic     mispredict,
    input  logic     is_branch,
    output logic     in_ready,
    output logic     stage_valid,
    output logic     commit,
    output logic     push_res,
    output logic     push_br,
    output logic     halted
);

    typedef enum logic [1:0] {
        ST_RUN,
        ST_SQUASH,
        ST_HALTED
    } state_t;

    state_t state;
    logic   epoch;
    logic   writes_reg;
    logic   hlt_commit;

    // wrong-path ops carry the old epoch
    assign commit     = stage_valid && (in_epoch == epoch);
    assign hlt_commit = commit && (in_op == OP_HLT);

    always_comb begin
        case (in_op)
            OP_ADD, OP_AND, OP_OR, OP_NOT, OP_SAL, OP_SAR, OP_MOV, OP_XCHG: writes_reg = 1'b1;
            // conditional move only on CF
            OP_CMOVC: writes_reg = cmov_ok;
            default:  writes_reg = 1'b0;
        endcase
    end

    assign push_res = commit && writes_reg;
    assign push_br  = commit && is_branch;
    assign halted   = (state == ST_HALTED);

    // stop taking ops as soon as HLT commits
    assign in_ready = (state != ST_HALTED) && space_ok && !hlt_commit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_RUN;
            epoch       <= 1'b0;
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid && in_ready;
            if (hlt_commit) begin
                state <= ST_HALTED;
            end else if (commit && mispredict) begin
                // flush younger ops by epoch
                state <= ST_SQUASH;
                epoch <= ~epoch;
            end else if (commit && (state == ST_SQUASH)) begin
                // first op on the correct path
                state <= ST_RUN;
            end
        end
    end

endmodule

//--- source/exec_flags.sv
// arithmetic flags register, bits change only when we and their mask bit are both set
`timescale 1ns/1ps

module exec_flags import exec_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  logic [FLAG_W-1:0] flags_new,
    input  logic [FLAG_W-1:0] flags_we,
    output logic [FLAG_W-1:0] flags,
    output logic              cmov_ok
);

    logic [FLAG_W-1:0] flags_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            flags_q <= '0;
        end else if (we) begin
            // merge written bits over the old value
            flags_q <= (flags_q & ~flags_we) | (flags_new & flags_we);
        end
    end

    assign flags = flags_q;

    // CMOVC condition, opcode check lives in the FSM
    assign cmov_ok = flags_q[FLAG_CF];

endmodule

//--- source/exec_out_queue.sv
// output FIFO, the caller never pushes into a full queue, QUEUE_DEPTH a power of two
`timescale 1ns/1ps

module exec_out_queue import exec_pkg::*; #(
    parameter type entry_t = logic [DATA_W-1:0]
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop_ok,
    output logic   out_valid,
    output entry_t out_data,
    output logic   two_free
);

    entry_t              mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0]   rd_ptr;
    logic [QPTR_W-1:0]   wr_ptr;
    logic [QCNT_W-1:0]   count;
    logic                do_pop;

    assign out_valid = (count != '0);
    assign do_pop    = out_valid && pop_ok;
    // head entry straight from the storage registers
    assign out_data  = mem[rd_ptr];
    // room for the staged op plus one more
    assign two_free  = (count <= QCNT_W'(QUEUE_DEPTH - 2));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/exec_pkg.sv
// shared definitions for the exec stage, QUEUE_DEPTH must be a power of two and at least 2
package exec_pkg;

    // operation codes from the decoder
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_NOT   = 4'd4,
        OP_SAL   = 4'd5,
        OP_SAR   = 4'd6,
        OP_MOV   = 4'd7,
        OP_CMOVC = 4'd8,
        OP_XCHG  = 4'd9,
        OP_JMP   = 4'd10,
        OP_JC    = 4'd11,
        OP_JZ    = 4'd12,
        OP_HLT   = 4'd13
    } exec_op_t;

    localparam int DATA_W = 32;
    localparam int DEST_W = 3;

    // arithmetic flags, no AF or DF
    localparam int FLAG_W  = 5;
    localparam int FLAG_CF = 0;
    localparam int FLAG_PF = 1;
    localparam int FLAG_ZF = 2;
    localparam int FLAG_SF = 3;
    localparam int FLAG_OF = 4;

    // credits and output queues
    localparam int EXEC_CREDITS = 4;
    localparam int CREDIT_W     = $clog2(EXEC_CREDITS + 1);
    localparam int QUEUE_DEPTH  = 4;
    localparam int QPTR_W       = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W       = $clog2(QUEUE_DEPTH + 1);

    // writeback payload, second write only for XCHG
    typedef struct packed {
        logic [DATA_W-1:0] data1;
        logic [DEST_W-1:0] dest1;
        logic [DATA_W-1:0] data2;
        logic [DEST_W-1:0] dest2;
        logic              two;
    } result_entry_t;

    // fetch payload
    typedef struct packed {
        logic              taken;
        logic              mispredict;
        logic [DATA_W-1:0] target;
    } branch_entry_t;

endpackage

//--- source/exec_top.sv
// integer execute stage, 32-bit register operands only, HLT stops the stage until rst
`timescale 1ns/1ps

module exec_top import exec_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // upstream valid/ready
    input  logic              in_valid,
    input  exec_op_t          in_op,
    input  logic              in_epoch,
    input  logic [DATA_W-1:0] in_op1,
    input  logic [DATA_W-1:0] in_op2,
    input  logic [DEST_W-1:0] in_dest1,
    input  logic [DEST_W-1:0] in_dest2,
    input  logic [DATA_W-1:0] in_next_eip,
    input  logic              in_pred_taken,
    input  logic [DATA_W-1:0] in_pred_target,
    output logic              in_ready,
    // writeback, credit based
    output logic              res_valid,
    output logic [DATA_W-1:0] res_data1,
    output logic [DEST_W-1:0] res_dest1,
    output logic [DATA_W-1:0] res_data2,
    output logic [DEST_W-1:0] res_dest2,
    output logic              res_two,
    input  logic              res_credit,
    // fetch, credit based
    output logic              br_valid,
    output logic              br_taken,
    output logic              br_mispredict,
    output logic [DATA_W-1:0] br_target,
    input  logic              br_credit,
    // status
    output logic [FLAG_W-1:0] flags,
    output logic              halted
);

    // issue stage payload
    exec_op_t          stage_op;
    logic              stage_epoch;
    logic [DATA_W-1:0] stage_op1;
    logic [DATA_W-1:0] stage_op2;
    logic [DEST_W-1:0] stage_dest1;
    logic [DEST_W-1:0] stage_dest2;
    logic [DATA_W-1:0] stage_next_eip;
    logic              stage_pred_taken;
    logic [DATA_W-1:0] stage_pred_target;

    logic              accept;
    logic              commit;
    logic              push_res;
    logic              push_br;
    logic              space_ok;
    logic [DATA_W-1:0] alu_data1;
    logic [DATA_W-1:0] alu_data2;
    logic [FLAG_W-1:0] flags_new;
    logic [FLAG_W-1:0] flags_we;
    logic              cmov_ok;
    logic              is_branch;
    logic              taken;
    logic              mispredict;
    logic [DATA_W-1:0] resolved_target;

    result_entry_t     res_push_data;
    result_entry_t     res_head;
    logic              res_q_valid;
    logic              res_two_free;
    logic              res_has_credit;
    branch_entry_t     br_push_data;
    branch_entry_t     br_head;
    logic              br_q_valid;
    logic              br_two_free;
    logic              br_has_credit;

    assign accept = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_op          <= in_op;
            stage_epoch       <= in_epoch;
            stage_op1         <= in_op1;
            stage_op2         <= in_op2;
            stage_dest1       <= in_dest1;
            stage_dest2       <= in_dest2;
            stage_next_eip    <= in_next_eip;
            stage_pred_taken  <= in_pred_taken;
            stage_pred_target <= in_pred_target;
        end
    end

    exec_alu u_alu (
        .op        (stage_op),
        .op1       (stage_op1),
        .op2       (stage_op2),
        .flags_cur (flags),
        .data1     (alu_data1),
        .data2     (alu_data2),
        .flags_new (flags_new),
        .flags_we  (flags_we)
    );

    // flags written only by ops that commit
    exec_flags u_flags (
        .clk       (clk),
        .rst       (rst),
        .we        (commit),
        .flags_new (flags_new),
        .flags_we  (flags_we),
        .flags     (flags),
        .cmov_ok   (cmov_ok)
    );

    exec_branch u_branch (
        .op              (stage_op),
        .flags           (flags),
        .target          (stage_op2),
        .next_eip        (stage_next_eip),
        .pred_target     (stage_pred_target),
        .pred_taken      (stage_pred_taken),
        .is_branch       (is_branch),
        .taken           (taken),
        .mispredict      (mispredict),
        .resolved_target (resolved_target)
    );

    assign space_ok = res_two_free && br_two_free;

    // stage valid bit stays inside the FSM
    exec_ctrl_fsm u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_epoch    (stage_epoch),
        .in_op       (stage_op),
        .space_ok    (space_ok),
        .cmov_ok     (cmov_ok),
        .mispredict  (mispredict),
        .is_branch   (is_branch),
        .in_ready    (in_ready),
        .stage_valid (),
        .commit      (commit),
        .push_res    (push_res),
        .push_br     (push_br),
        .halted      (halted)
    );

    // XCHG is the only op with a second write
    assign res_push_data = '{
        data1: alu_data1,
        dest1: stage_dest1,
        data2: alu_data2,
        dest2: stage_dest2,
        two:   (stage_op == OP_XCHG)
    };
    assign br_push_data = '{taken: taken, mispredict: mispredict, target: resolved_target};

    exec_out_queue #(.entry_t(result_entry_t)) u_res_q (
        .clk       (clk),
        .rst       (rst),
        .push      (push_res),
        .push_data (res_push_data),
        .pop_ok    (res_has_credit),
        .out_valid (res_q_valid),
        .out_data  (res_head),
        .two_free  (res_two_free)
    );

    exec_out_queue #(.entry_t(branch_entry_t)) u_br_q (
        .clk       (clk),
        .rst       (rst),
        .push      (push_br),
        .push_data (br_push_data),
        .pop_ok    (br_has_credit),
        .out_valid (br_q_valid),
        .out_data  (br_head),
        .two_free  (br_two_free)
    );

    // a beat is a pop and spends one credit
    assign res_valid = res_q_valid && res_has_credit;
    assign br_valid  = br_q_valid && br_has_credit;

    exec_credit_counter u_res_credit (
        .clk           (clk),
        .rst           (rst),
        .credit_return (res_credit),
        .spend         (res_valid),
        .has_credit    (res_has_credit)
    );

    exec_credit_counter u_br_credit (
        .clk           (clk),
        .rst           (rst),
        .credit_return (br_credit),
        .spend         (br_valid),
        .has_credit    (br_has_credit)
    );

    assign res_data1     = res_head.data1;
    assign res_dest1     = res_head.dest1;
    assign res_data2     = res_head.data2;
    assign res_dest2     = res_head.dest2;
    assign res_two       = res_head.two;
    assign br_taken      = br_head.taken;
    assign br_mispredict = br_head.mispredict;
    assign br_target     = br_head.target;

endmodule
